// ==== oq_pkg.sv ====
package oq_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH         = 32;
    localparam int KEEP_WIDTH         = 4;
    localparam int BUF_DEPTH          = 64;
    localparam int BUF_ADDR_WIDTH     = 6;
    localparam int RANK_WIDTH         = 8;
    localparam int CAL_DEPTH          = 16;
    localparam int CAL_COUNT_WIDTH    = 5;
    // almost full once fewer free words than this remain
    localparam int ALMOST_FULL_MARGIN = 8;

    localparam int BUF_WORD_WIDTH = DATA_WIDTH + KEEP_WIDTH + 1 + BUF_ADDR_WIDTH;

    // stored word layout, msb first: data, keep, last, next address
    localparam int WORD_NEXT_LSB = 0;
    localparam int WORD_LAST_BIT = WORD_NEXT_LSB + BUF_ADDR_WIDTH;
    localparam int WORD_KEEP_LSB = WORD_LAST_BIT + 1;
    localparam int WORD_DATA_LSB = WORD_KEEP_LSB + KEEP_WIDTH;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [BUF_ADDR_WIDTH-1:0] buf_addr_t;
    typedef logic [RANK_WIDTH-1:0]     rank_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [KEEP_WIDTH-1:0]     keep_t;
    typedef logic [BUF_ADDR_WIDTH:0]   buf_count_t;
    typedef logic [BUF_WORD_WIDTH-1:0] buf_word_t;

    typedef enum logic [1:0]
    {
        DEQ_IDLE,
        DEQ_REQ,
        DEQ_WAIT,
        DEQ_SEND
    } deq_state_t;

endpackage

// ==== buf_rd_if.sv ====
`timescale 1ns/1ns

interface buf_rd_if;

    // request side, held stable until req_ready
    logic        req_valid;
    logic        req_ready;
    logic [5:0]  req_addr;

    // response one cycle after the handshake
    logic        resp_valid;
    logic [42:0] resp_word;

    modport requester
    (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  resp_valid,
        input  resp_word
    );

    modport arbiter
    (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output resp_valid,
        output resp_word
    );

endinterface

// ==== free_list.sv ====
`timescale 1ns/1ns

module free_list
(
    input  logic               axis_aclk,
    input  logic               axis_resetn,
    input  logic               alloc_en,
    input  logic               release_en,
    input  oq_pkg::buf_addr_t  release_addr,
    output oq_pkg::buf_addr_t  alloc_addr,
    output oq_pkg::buf_addr_t  alloc_next,
    output oq_pkg::buf_count_t free_count,
    output logic               almost_full
);
    import oq_pkg::*;

    buf_addr_t  addr_q [BUF_DEPTH];
    buf_addr_t  head;
    buf_addr_t  head_p1;
    buf_addr_t  tail;
    buf_count_t count;

    // pointers wrap at the buffer depth
    assign head_p1 = head + 1'b1;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            head  <= '0;
            tail  <= '0;
            count <= buf_count_t'(BUF_DEPTH);
            // every address free, in order
            for (int i = 0; i < BUF_DEPTH; i++)
            begin
                addr_q[i] <= buf_addr_t'(i);
            end
        end
        else
        begin
            if (alloc_en)
            begin
                head <= head_p1;
            end
            if (release_en)
            begin
                addr_q[tail] <= release_addr;
                tail         <= tail + 1'b1;
            end
            count <= count + buf_count_t'(release_en) - buf_count_t'(alloc_en);
        end
    end

    // two oldest entries, so a word knows its successor
    assign alloc_addr  = addr_q[head];
    assign alloc_next  = addr_q[head_p1];
    assign free_count  = count;
    assign almost_full = count < buf_count_t'(ALMOST_FULL_MARGIN);

endmodule

// ==== pkt_buffer.sv ====
`timescale 1ns/1ns

module pkt_buffer
(
    input  logic              axis_aclk,
    input  logic              wr_en,
    input  oq_pkg::buf_addr_t wr_addr,
    input  oq_pkg::buf_word_t wr_word,
    input  logic              rd_en,
    input  oq_pkg::buf_addr_t rd_addr,
    output oq_pkg::buf_word_t rd_word
);
    import oq_pkg::*;

    buf_word_t mem [BUF_DEPTH];

    // write port, owned by the enqueue side
    always_ff @(posedge axis_aclk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_word;
        end
    end

    // registered read, word valid the cycle after rd_en
    always_ff @(posedge axis_aclk)
    begin
        if (rd_en)
        begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

// ==== buf_read_arbiter.sv ====
`timescale 1ns/1ns

module buf_read_arbiter
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,
    input  oq_pkg::buf_word_t rd_word,
    output logic              rd_en,
    output oq_pkg::buf_addr_t rd_addr,
    buf_rd_if.arbiter         deq_rd,
    buf_rd_if.arbiter         cpu_rd
);

    logic cpu_first;
    logic grant_deq;
    logic grant_cpu;
    logic deq_resp_q;
    logic cpu_resp_q;

    // round robin, the last winner loses a tie
    assign grant_deq = deq_rd.req_valid && (!cpu_rd.req_valid || !cpu_first);
    assign grant_cpu = cpu_rd.req_valid && !grant_deq;

    assign deq_rd.req_ready = grant_deq;
    assign cpu_rd.req_ready = grant_cpu;

    assign rd_en   = grant_deq || grant_cpu;
    assign rd_addr = grant_cpu ? cpu_rd.req_addr : deq_rd.req_addr;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            cpu_first  <= 1'b0;
            deq_resp_q <= 1'b0;
            cpu_resp_q <= 1'b0;
        end
        else
        begin
            deq_resp_q <= grant_deq;
            cpu_resp_q <= grant_cpu;
            if (grant_deq)
            begin
                cpu_first <= 1'b1;
            end
            else if (grant_cpu)
            begin
                cpu_first <= 1'b0;
            end
        end
    end

    // buffer output goes to both, only the granted one sees valid
    assign deq_rd.resp_valid = deq_resp_q;
    assign deq_rd.resp_word  = rd_word;
    assign cpu_rd.resp_valid = cpu_resp_q;
    assign cpu_rd.resp_word  = rd_word;

endmodule

// ==== pifo_calendar.sv ====
`timescale 1ns/1ns

module pifo_calendar
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,
    input  logic              insert_en,
    input  oq_pkg::rank_t     insert_rank,
    input  oq_pkg::buf_addr_t insert_addr,
    input  logic              pop_en,
    output logic              top_valid,
    output oq_pkg::buf_addr_t top_addr,
    output logic              full
);
    import oq_pkg::*;

    rank_t     rank_q   [CAL_DEPTH];
    buf_addr_t addr_q   [CAL_DEPTH];
    rank_t     rank_mid [CAL_DEPTH];
    buf_addr_t addr_mid [CAL_DEPTH];
    rank_t     rank_nxt [CAL_DEPTH];
    buf_addr_t addr_nxt [CAL_DEPTH];

    logic [CAL_COUNT_WIDTH-1:0] count;
    logic [CAL_COUNT_WIDTH-1:0] count_mid;
    logic [CAL_COUNT_WIDTH-1:0] pos;
    logic                       do_pop;
    logic                       do_ins;

    assign top_valid = count != '0;
    assign full      = count == CAL_COUNT_WIDTH'(CAL_DEPTH);
    assign top_addr  = addr_q[0];

    assign do_pop    = pop_en && top_valid;
    assign count_mid = count - CAL_COUNT_WIDTH'(do_pop);
    assign do_ins    = insert_en && (count_mid < CAL_COUNT_WIDTH'(CAL_DEPTH));

    ////////////////////////////////////////////////////////////
    // pop first, shifting the rest towards the head
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        for (int i = 0; i < CAL_DEPTH - 1; i++)
        begin
            rank_mid[i] = do_pop ? rank_q[i + 1] : rank_q[i];
            addr_mid[i] = do_pop ? addr_q[i + 1] : addr_q[i];
        end
        rank_mid[CAL_DEPTH-1] = rank_q[CAL_DEPTH-1];
        addr_mid[CAL_DEPTH-1] = addr_q[CAL_DEPTH-1];
    end

    ////////////////////////////////////////////////////////////
    // then insert behind every entry of lower or equal rank
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        pos = '0;
        for (int i = 0; i < CAL_DEPTH; i++)
        begin
            if (i < count_mid && rank_mid[i] <= insert_rank)
            begin
                pos = pos + 1'b1;
            end
        end
        rank_nxt[0] = rank_mid[0];
        addr_nxt[0] = addr_mid[0];
        for (int i = 1; i < CAL_DEPTH; i++)
        begin
            rank_nxt[i] = (do_ins && i > pos) ? rank_mid[i - 1] : rank_mid[i];
            addr_nxt[i] = (do_ins && i > pos) ? addr_mid[i - 1] : addr_mid[i];
        end
        if (do_ins)
        begin
            rank_nxt[pos[CAL_COUNT_WIDTH-2:0]] = insert_rank;
            addr_nxt[pos[CAL_COUNT_WIDTH-2:0]] = insert_addr;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            count <= '0;
        end
        else
        begin
            count <= count_mid + CAL_COUNT_WIDTH'(do_ins);
        end
    end

    // entries beyond count are don't care
    always_ff @(posedge axis_aclk)
    begin
        rank_q <= rank_nxt;
        addr_q <= addr_nxt;
    end

endmodule

// ==== enqueue_writer.sv ====
`timescale 1ns/1ns

module enqueue_writer
(
    input  logic               axis_aclk,
    input  logic               axis_resetn,
    input  oq_pkg::data_t      s_axis_tdata,
    input  oq_pkg::keep_t      s_axis_tkeep,
    input  logic               s_axis_tlast,
    input  oq_pkg::rank_t      s_axis_trank,
    input  logic               s_axis_tvalid,
    input  oq_pkg::buf_addr_t  alloc_addr,
    input  oq_pkg::buf_addr_t  alloc_next,
    input  oq_pkg::buf_count_t free_count,
    input  logic               cal_full,
    output logic               s_axis_tready,
    output logic               alloc_en,
    output logic               wr_en,
    output oq_pkg::buf_addr_t  wr_addr,
    output oq_pkg::buf_word_t  wr_word,
    output logic               insert_en,
    output oq_pkg::rank_t      insert_rank,
    output oq_pkg::buf_addr_t  insert_addr
);
    import oq_pkg::*;

    logic      in_pkt;
    logic      running;
    logic      accept;
    buf_addr_t first_addr;
    rank_t     first_rank;

    // keep room for the successor pointer, and a calendar slot per new packet
    assign s_axis_tready = running && (free_count >= buf_count_t'(2)) && (in_pkt || !cal_full);
    assign accept        = s_axis_tvalid && s_axis_tready;

    assign alloc_en = accept;
    assign wr_en    = accept;
    assign wr_addr  = alloc_addr;
    assign wr_word  = {s_axis_tdata, s_axis_tkeep, s_axis_tlast, alloc_next};

    // single-word packets take address and rank straight from this beat
    assign insert_en   = accept && s_axis_tlast;
    assign insert_addr = in_pkt ? first_addr : alloc_addr;
    assign insert_rank = in_pkt ? first_rank : s_axis_trank;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            in_pkt  <= 1'b0;
            running <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (accept)
            begin
                in_pkt <= !s_axis_tlast;
            end
        end
    end

    // first word of a packet
    always_ff @(posedge axis_aclk)
    begin
        if (accept && !in_pkt)
        begin
            first_addr <= alloc_addr;
            first_rank <= s_axis_trank;
        end
    end

endmodule

// ==== dequeue_engine.sv ====
`timescale 1ns/1ns

module dequeue_engine
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,
    input  logic              top_valid,
    input  oq_pkg::buf_addr_t top_addr,
    input  logic              m_axis_tready,
    output logic              pop_en,
    output logic              release_en,
    output oq_pkg::buf_addr_t release_addr,
    output oq_pkg::data_t     m_axis_tdata,
    output oq_pkg::keep_t     m_axis_tkeep,
    output logic              m_axis_tlast,
    output logic              m_axis_tvalid,
    buf_rd_if.requester       deq_rd
);
    import oq_pkg::*;

    deq_state_t state;
    buf_addr_t  cur_addr;
    buf_word_t  word_q;

    assign pop_en           = (state == DEQ_IDLE) && top_valid;
    assign deq_rd.req_valid = (state == DEQ_REQ);
    assign deq_rd.req_addr  = cur_addr;

    // held word
    assign m_axis_tvalid = (state == DEQ_SEND);
    assign m_axis_tdata  = word_q[WORD_DATA_LSB +: DATA_WIDTH];
    assign m_axis_tkeep  = word_q[WORD_KEEP_LSB +: KEEP_WIDTH];
    assign m_axis_tlast  = word_q[WORD_LAST_BIT];

    // a sent word frees its address
    assign release_en   = m_axis_tvalid && m_axis_tready;
    assign release_addr = cur_addr;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state <= DEQ_IDLE;
        end
        else
        begin
            case (state)
                DEQ_IDLE:
                begin
                    if (top_valid)
                    begin
                        state <= DEQ_REQ;
                    end
                end
                DEQ_REQ:
                begin
                    if (deq_rd.req_ready)
                    begin
                        state <= DEQ_WAIT;
                    end
                end
                DEQ_WAIT:
                begin
                    if (deq_rd.resp_valid)
                    begin
                        state <= DEQ_SEND;
                    end
                end
                DEQ_SEND:
                begin
                    if (m_axis_tready)
                    begin
                        state <= m_axis_tlast ? DEQ_IDLE : DEQ_REQ;
                    end
                end
                default:
                begin
                    state <= DEQ_IDLE;
                end
            endcase
        end
    end

    // walk the chain
    always_ff @(posedge axis_aclk)
    begin
        if (pop_en)
        begin
            cur_addr <= top_addr;
        end
        else if (release_en && !m_axis_tlast)
        begin
            cur_addr <= word_q[WORD_NEXT_LSB +: BUF_ADDR_WIDTH];
        end
        if (deq_rd.resp_valid)
        begin
            word_q <= deq_rd.resp_word;
        end
    end

endmodule

// ==== output_queue.sv ====
`timescale 1ns/1ns

module output_queue
(
    input  logic               axis_aclk,
    input  logic               axis_resetn,
    // input stream
    input  oq_pkg::data_t      s_axis_tdata,
    input  oq_pkg::keep_t      s_axis_tkeep,
    input  logic               s_axis_tlast,
    input  oq_pkg::rank_t      s_axis_trank,
    input  logic               s_axis_tvalid,
    output logic               s_axis_tready,
    // output stream
    output oq_pkg::data_t      m_axis_tdata,
    output oq_pkg::keep_t      m_axis_tkeep,
    output logic               m_axis_tlast,
    output logic               m_axis_tvalid,
    input  logic               m_axis_tready,
    // cpu buffer read
    input  logic               cpu_rd_req_valid,
    output logic               cpu_rd_req_ready,
    input  oq_pkg::buf_addr_t  cpu_rd_req_addr,
    output logic               cpu_rd_resp_valid,
    output oq_pkg::buf_word_t  cpu_rd_resp_word,
    // status
    output oq_pkg::buf_count_t buffer_remain,
    output logic               buffer_almost_full,
    output logic               calendar_full
);
    import oq_pkg::*;

    buf_rd_if deq_rd ();
    buf_rd_if cpu_rd ();

    buf_addr_t  alloc_addr;
    buf_addr_t  alloc_next;
    buf_count_t free_count;
    logic       alloc_en;
    logic       release_en;
    buf_addr_t  release_addr;
    logic       wr_en;
    buf_addr_t  wr_addr;
    buf_word_t  wr_word;
    logic       rd_en;
    buf_addr_t  rd_addr;
    buf_word_t  rd_word;
    logic       insert_en;
    rank_t      insert_rank;
    buf_addr_t  insert_addr;
    logic       pop_en;
    logic       top_valid;
    buf_addr_t  top_addr;

    // cpu port onto its requester interface
    assign cpu_rd.req_valid  = cpu_rd_req_valid;
    assign cpu_rd.req_addr   = cpu_rd_req_addr;
    assign cpu_rd_req_ready  = cpu_rd.req_ready;
    assign cpu_rd_resp_valid = cpu_rd.resp_valid;
    assign cpu_rd_resp_word  = cpu_rd.resp_word;

    assign buffer_remain = free_count;

    free_list free_list_i
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .alloc_en     (alloc_en),
        .release_en   (release_en),
        .release_addr (release_addr),
        .alloc_addr   (alloc_addr),
        .alloc_next   (alloc_next),
        .free_count   (free_count),
        .almost_full  (buffer_almost_full)
    );

    pkt_buffer pkt_buffer_i
    (
        .axis_aclk (axis_aclk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_word   (wr_word),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_word   (rd_word)
    );

    buf_read_arbiter buf_read_arbiter_i
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .rd_word     (rd_word),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .deq_rd      (deq_rd.arbiter),
        .cpu_rd      (cpu_rd.arbiter)
    );

    pifo_calendar pifo_calendar_i
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .insert_en   (insert_en),
        .insert_rank (insert_rank),
        .insert_addr (insert_addr),
        .pop_en      (pop_en),
        .top_valid   (top_valid),
        .top_addr    (top_addr),
        .full        (calendar_full)
    );

    enqueue_writer enqueue_writer_i
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_trank  (s_axis_trank),
        .s_axis_tvalid (s_axis_tvalid),
        .alloc_addr    (alloc_addr),
        .alloc_next    (alloc_next),
        .free_count    (free_count),
        .cal_full      (calendar_full),
        .s_axis_tready (s_axis_tready),
        .alloc_en      (alloc_en),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_word       (wr_word),
        .insert_en     (insert_en),
        .insert_rank   (insert_rank),
        .insert_addr   (insert_addr)
    );

    dequeue_engine dequeue_engine_i
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .top_valid     (top_valid),
        .top_addr      (top_addr),
        .m_axis_tready (m_axis_tready),
        .pop_en        (pop_en),
        .release_en    (release_en),
        .release_addr  (release_addr),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .deq_rd        (deq_rd.requester)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen
(
    output logic axis_aclk,
    output logic axis_resetn
);

    // 8 ns period
    initial
    begin
        axis_aclk = 1'b0;
        forever
        begin
            #4 axis_aclk = ~axis_aclk;
        end
    end

    // reset held for 8 cycles, released on a falling edge
    initial
    begin
        axis_resetn = 1'b0;
        repeat (8) @(posedge axis_aclk);
        @(negedge axis_aclk);
        axis_resetn = 1'b1;
    end

endmodule

// ==== tb_output_queue.sv ====
`timescale 1ns/1ns

module tb_output_queue;
    import oq_pkg::*;

    // cpu read 2, single 8, rank order 7x8, random ready 40x8, calendar full 57+2
    localparam int MAX_WORDS = 2 + 8 + 7 * 8 + 40 * 8 + 59;
    localparam int MAX_PKTS  = 128;

    logic       axis_aclk;
    logic       axis_resetn;
    data_t      s_axis_tdata;
    keep_t      s_axis_tkeep;
    logic       s_axis_tlast;
    rank_t      s_axis_trank;
    logic       s_axis_tvalid;
    logic       s_axis_tready;
    data_t      m_axis_tdata;
    keep_t      m_axis_tkeep;
    logic       m_axis_tlast;
    logic       m_axis_tvalid;
    logic       m_axis_tready;
    logic       cpu_rd_req_valid;
    logic       cpu_rd_req_ready;
    buf_addr_t  cpu_rd_req_addr;
    logic       cpu_rd_resp_valid;
    buf_word_t  cpu_rd_resp_word;
    buf_count_t buffer_remain;
    logic       buffer_almost_full;
    logic       calendar_full;

    integer seed       = 29;
    string  test_name  = "reset";
    // 0 output held, 1 always ready, 2 random ready
    int     ready_mode = 0;

    ////////////////////////////////////////////////////////////
    // queue model
    ////////////////////////////////////////////////////////////

    int    free_q [$];
    data_t word_data [MAX_WORDS];
    keep_t word_keep [MAX_WORDS];
    int    word_addr [MAX_WORDS];
    int    pkt_first [MAX_PKTS];
    int    pkt_len   [MAX_PKTS];
    int    pkt_rank  [MAX_PKTS];
    // 0 unused, 1 stored, 2 leaving or gone
    int    pkt_state [MAX_PKTS];
    int    n_words    = 0;
    int    n_pkts     = 0;
    int    sent_words = 0;
    int    sent_pkts  = 0;

    tb_clock_gen tb_clock_gen_i
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn)
    );

    output_queue output_queue_i
    (
        .axis_aclk          (axis_aclk),
        .axis_resetn        (axis_resetn),
        .s_axis_tdata       (s_axis_tdata),
        .s_axis_tkeep       (s_axis_tkeep),
        .s_axis_tlast       (s_axis_tlast),
        .s_axis_trank       (s_axis_trank),
        .s_axis_tvalid      (s_axis_tvalid),
        .s_axis_tready      (s_axis_tready),
        .m_axis_tdata       (m_axis_tdata),
        .m_axis_tkeep       (m_axis_tkeep),
        .m_axis_tlast       (m_axis_tlast),
        .m_axis_tvalid      (m_axis_tvalid),
        .m_axis_tready      (m_axis_tready),
        .cpu_rd_req_valid   (cpu_rd_req_valid),
        .cpu_rd_req_ready   (cpu_rd_req_ready),
        .cpu_rd_req_addr    (cpu_rd_req_addr),
        .cpu_rd_resp_valid  (cpu_rd_resp_valid),
        .cpu_rd_resp_word   (cpu_rd_resp_word),
        .buffer_remain      (buffer_remain),
        .buffer_almost_full (buffer_almost_full),
        .calendar_full      (calendar_full)
    );

    // lowest rank leaves first and equal ranks keep arrival order
    function automatic int next_packet();
        int best;
        best = -1;
        for (int p = 0; p < n_pkts; p++)
        begin
            if (pkt_state[p] == 1 && (best < 0 || pkt_rank[p] < pkt_rank[best]))
            begin
                best = p;
            end
        end
        return best;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR test %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic step();
        @(negedge axis_aclk);
        #3;
    endtask

    task automatic set_ready(input int mode);
        @(negedge axis_aclk);
        #1;
        ready_mode = mode;
    endtask

    // free words are 64 minus the stored ones
    task automatic check_status();
        int remain;
        remain = BUF_DEPTH - (n_words - sent_words);
        check_value("buffer_remain", remain, buffer_remain);
        check_value("buffer_almost_full", remain < ALMOST_FULL_MARGIN, buffer_almost_full);
    endtask

    // first word sees s_axis_tready low for hold cycles before the output opens
    task automatic send_packet(input int len, input rank_t rank, input int hold);
        data_t d;
        keep_t k;
        int    base;
        base = 0;
        for (int w = 0; w < len; w++)
        begin
            d = $random(seed);
            k = $random(seed);
            @(negedge axis_aclk);
            s_axis_tvalid = 1'b1;
            s_axis_tdata  = d;
            s_axis_tkeep  = k;
            s_axis_tlast  = (w == len - 1);
            s_axis_trank  = rank;
            #1;
            if (w == 0 && hold > 0)
            begin
                repeat (hold)
                begin
                    check_value("s_axis_tready with calendar full", 0, s_axis_tready);
                    @(negedge axis_aclk);
                    #1;
                end
                base       = sent_pkts;
                ready_mode = 1;
            end
            while (!s_axis_tready)
            begin
                @(negedge axis_aclk);
                #1;
            end
            if (w == 0 && hold > 0)
            begin
                check_value("packet drained before accept", 1, sent_pkts > base);
            end
            // accepted on the coming edge with the next in-order free address
            word_data[n_words] = d;
            word_keep[n_words] = k;
            word_addr[n_words] = free_q.pop_front();
            n_words++;
        end
        pkt_first[n_pkts] = n_words - len;
        pkt_len[n_pkts]   = len;
        pkt_rank[n_pkts]  = rank;
        pkt_state[n_pkts] = 1;
        n_pkts++;
        @(negedge axis_aclk);
        s_axis_tvalid = 1'b0;
    endtask

    task automatic wait_drain();
        while (sent_pkts != n_pkts)
        begin
            step();
        end
        step();
    endtask

    // response exactly one cycle after the handshake
    task automatic cpu_read(input int addr, output buf_word_t word);
        @(negedge axis_aclk);
        cpu_rd_req_valid = 1'b1;
        cpu_rd_req_addr  = buf_addr_t'(addr);
        #1;
        while (!cpu_rd_req_ready)
        begin
            @(negedge axis_aclk);
            #1;
        end
        check_value("cpu_rd_resp_valid before handshake", 0, cpu_rd_resp_valid);
        @(negedge axis_aclk);
        cpu_rd_req_valid = 1'b0;
        check_value("cpu_rd_resp_valid after handshake", 1, cpu_rd_resp_valid);
        word = cpu_rd_resp_word;
        @(negedge axis_aclk);
        #1;
        check_value("cpu_rd_resp_valid one cycle", 0, cpu_rd_resp_valid);
    endtask

    always @(negedge axis_aclk)
    begin
        if (ready_mode == 2)
        begin
            m_axis_tready = $random(seed) & 1;
        end
        else
        begin
            m_axis_tready = (ready_mode == 1);
        end
    end

    ////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////

    initial
    begin : monitor
        int    cur;
        int    pos;
        int    idx;
        logic  held;
        data_t held_data;
        keep_t held_keep;
        logic  held_last;
        cur       = -1;
        pos       = 0;
        held      = 1'b0;
        held_data = '0;
        held_keep = '0;
        held_last = 1'b0;
        wait (axis_resetn === 1'b1);
        forever
        begin
            @(negedge axis_aclk);
            #2;
            if (held)
            begin
                check_value("m_axis_tvalid under back-pressure", 1, m_axis_tvalid);
                check_value("m_axis_tdata under back-pressure", held_data, m_axis_tdata);
                check_value("m_axis_tkeep under back-pressure", held_keep, m_axis_tkeep);
                check_value("m_axis_tlast under back-pressure", held_last, m_axis_tlast);
            end
            if (m_axis_tvalid && m_axis_tready)
            begin
                if (cur < 0)
                begin
                    cur = next_packet();
                    pos = 0;
                    if (cur < 0)
                    begin
                        $display("an output word appeared while no packet was stored");
                        abort_run();
                    end
                    pkt_state[cur] = 2;
                end
                idx = pkt_first[cur] + pos;
                check_value("m_axis_tdata", word_data[idx], m_axis_tdata);
                check_value("m_axis_tkeep", word_keep[idx], m_axis_tkeep);
                check_value("m_axis_tlast", pos == pkt_len[cur] - 1, m_axis_tlast);
                free_q.push_back(word_addr[idx]);
                sent_words++;
                pos++;
                if (pos == pkt_len[cur])
                begin
                    cur = -1;
                    sent_pkts++;
                end
            end
            held      = m_axis_tvalid && !m_axis_tready;
            held_data = m_axis_tdata;
            held_keep = m_axis_tkeep;
            held_last = m_axis_tlast;
        end
    end

    initial
    begin
        repeat (200 * MAX_WORDS + 2000) @(posedge axis_aclk);
        $display("timeout, the test sequence did not finish in time");
        abort_run();
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        buf_word_t rd;
        int        len;
        rank_t     rank;
        s_axis_tvalid    = 1'b0;
        s_axis_tdata     = '0;
        s_axis_tkeep     = '0;
        s_axis_tlast     = 1'b0;
        s_axis_trank     = '0;
        m_axis_tready    = 1'b0;
        cpu_rd_req_valid = 1'b0;
        cpu_rd_req_addr  = '0;
        for (int i = 0; i < BUF_DEPTH; i++)
        begin
            free_q.push_back(i);
        end

        repeat (4) @(negedge axis_aclk);
        #1;
        check_value("m_axis_tvalid in reset", 0, m_axis_tvalid);
        check_value("s_axis_tready in reset", 0, s_axis_tready);
        check_value("cpu_rd_req_ready in reset", 0, cpu_rd_req_ready);
        check_value("cpu_rd_resp_valid in reset", 0, cpu_rd_resp_valid);
        check_value("buffer_remain in reset", BUF_DEPTH, buffer_remain);
        check_value("calendar_full in reset", 0, calendar_full);
        wait (axis_resetn === 1'b1);
        repeat (2) @(negedge axis_aclk);

        // cpu reads while the output is held
        test_name = "cpu_read";
        send_packet(2, 8'd3, 0);
        for (int w = 0; w < 2; w++)
        begin
            cpu_read(word_addr[w], rd);
            check_value("stored data", word_data[w], rd[42:11]);
            check_value("stored last", w == 1, rd[6]);
            check_value("stored next pointer", word_addr[w] + 1, rd[5:0]);
        end
        set_ready(1);
        wait_drain();

        test_name = "single_packet";
        len = 1 + ($random(seed) & 7);
        send_packet(len, $random(seed), 0);
        wait_drain();

        // a rank 0 packet fills the dequeue engine while the rest wait in the calendar
        test_name = "rank_order";
        set_ready(0);
        send_packet(1 + ($random(seed) & 7), 8'd0, 0);
        for (int p = 0; p < 6; p++)
        begin
            send_packet(1 + ($random(seed) & 7), 1 + ($random(seed) & 3), 0);
        end
        step();
        check_status();
        set_ready(1);
        wait_drain();
        check_status();

        // ranks never fall, so arrival timing cannot change the order
        test_name = "random_ready";
        set_ready(2);
        rank = 8'd0;
        for (int p = 0; p < 40; p++)
        begin
            rank = rank + ($random(seed) & 1);
            send_packet(1 + ($random(seed) & 7), rank, 0);
        end
        set_ready(1);
        wait_drain();
        check_status();

        // one packet in the engine plus 16 in the calendar hold 57 words
        test_name = "calendar_full";
        set_ready(0);
        send_packet(9, 8'd0, 0);
        for (int p = 0; p < 16; p++)
        begin
            send_packet(3, 1 + ($random(seed) & 127), 0);
        end
        step();
        check_value("calendar_full", 1, calendar_full);
        check_status();
        send_packet(2, 8'd255, 20);
        wait_drain();
        check_status();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
oq_pkg.sv
buf_rd_if.sv
free_list.sv
pkt_buffer.sv
buf_read_arbiter.sv
pifo_calendar.sv
enqueue_writer.sv
dequeue_engine.sv
output_queue.sv
tb_clock_gen.sv
tb_output_queue.sv

// ==== Bender.yml ====
package:
  name: output_queue

sources:
  - oq_pkg.sv
  - buf_rd_if.sv
  - free_list.sv
  - pkt_buffer.sv
  - buf_read_arbiter.sv
  - pifo_calendar.sv
  - enqueue_writer.sv
  - dequeue_engine.sv
  - output_queue.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_output_queue.sv
